// File: hw/split_cache_pkg.sv
package split_cache_pkg;

	// word and address widths of the 16-bit processor bus
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// a cache line holds four consecutive words
	localparam int LINE_WORDS = 4;

	// word select bits sit at the bottom of every address
	localparam int OFFSET_W = $clog2(LINE_WORDS);

	// line address as sent to the main store
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// word k of a line lives at index [k]
	typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

	// cache controller states
	// the instruction cache never enters C_WRITEBACK
	typedef enum logic [1:0] {
		C_IDLE,
		C_WRITEBACK,
		C_REFILL
	} cache_state_t;

	// line operations a cache can ask of the main store
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_READ_LINE,
		MEM_WRITE_LINE
	} mem_op_t;

endpackage

// File: hw/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int N_LINES = 8
) (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  logic                                    i_read,
	input  logic [split_cache_pkg::ADDR_W-1:0]      i_addr,
	output logic [split_cache_pkg::WORD_W-1:0]      o_data,
	output logic                                    o_busy,
	output split_cache_pkg::mem_op_t                o_mem_op,
	output logic [split_cache_pkg::LINE_ADDR_W-1:0] o_mem_line_addr,
	input  logic                                    i_mem_done,
	input  split_cache_pkg::line_t                  i_mem_rline
);
	import split_cache_pkg::*;

	localparam int IDX_W = $clog2(N_LINES);
	localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

	cache_state_t state_q;
	logic [N_LINES-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [N_LINES];
	line_t data_q [N_LINES];

	logic [OFFSET_W-1:0] word;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;

	// requester holds i_addr while busy, so it is also the miss address
	assign word = i_addr[OFFSET_W-1:0];
	assign idx = i_addr[OFFSET_W+IDX_W-1:OFFSET_W];
	assign tag = i_addr[ADDR_W-1:OFFSET_W+IDX_W];
	assign hit = valid_q[idx] && (tag_q[idx] == tag);

	assign o_busy = (state_q != C_IDLE);
	assign o_mem_line_addr = i_addr[ADDR_W-1:OFFSET_W];

	// request drops in the done cycle so the store never takes it twice
	assign o_mem_op = (state_q == C_REFILL && !i_mem_done) ? MEM_READ_LINE : MEM_IDLE;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= C_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				C_IDLE: begin
					if (i_read && !hit)
						state_q <= C_REFILL;
				end
				C_REFILL: begin
					if (i_mem_done) begin
						valid_q[idx] <= 1'b1;
						state_q <= C_IDLE;
					end
				end
				default: begin
					state_q <= C_IDLE;
				end
			endcase
		end
	end

	// hit read and refill both answer at the edge that ends the request
	always_ff @(posedge clk) begin
		if (state_q == C_IDLE && i_read && hit) begin
			o_data <= data_q[idx][word];
		end else if (state_q == C_REFILL && i_mem_done) begin
			data_q[idx] <= i_mem_rline;
			tag_q[idx] <= tag;
			o_data <= i_mem_rline[word];
		end
	end

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ps

module dcache #(
	parameter int N_LINES = 8
) (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  logic                                    i_read,
	input  logic                                    i_write,
	input  logic [split_cache_pkg::ADDR_W-1:0]      i_addr,
	input  logic [split_cache_pkg::WORD_W-1:0]      i_wdata,
	output logic [split_cache_pkg::WORD_W-1:0]      o_rdata,
	output logic                                    o_busy,
	output split_cache_pkg::mem_op_t                o_mem_op,
	output logic [split_cache_pkg::LINE_ADDR_W-1:0] o_mem_line_addr,
	output split_cache_pkg::line_t                  o_mem_wline,
	input  logic                                    i_mem_done,
	input  split_cache_pkg::line_t                  i_mem_rline
);
	import split_cache_pkg::*;

	localparam int IDX_W = $clog2(N_LINES);
	localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

	cache_state_t state_q;
	logic [N_LINES-1:0] valid_q;
	logic [N_LINES-1:0] dirty_q;
	logic [TAG_W-1:0] tag_q [N_LINES];
	line_t data_q [N_LINES];

	logic [OFFSET_W-1:0] word;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic req;
	logic hit;
	logic hit_accept;
	logic victim_dirty;
	logic refill_done;
	line_t fill_line;

	assign word = i_addr[OFFSET_W-1:0];
	assign idx = i_addr[OFFSET_W+IDX_W-1:OFFSET_W];
	assign tag = i_addr[ADDR_W-1:OFFSET_W+IDX_W];

	assign req = i_read || i_write;
	assign hit = valid_q[idx] && (tag_q[idx] == tag);
	assign hit_accept = (state_q == C_IDLE) && req && hit;
	assign victim_dirty = valid_q[idx] && dirty_q[idx];
	assign refill_done = (state_q == C_REFILL) && i_mem_done;

	assign o_busy = (state_q != C_IDLE);

	// victim line stays untouched until the refill lands
	assign o_mem_wline = data_q[idx];

	// a write miss merges its word into the returned line
	always_comb begin
		fill_line = i_mem_rline;
		if (i_write)
			fill_line[word] = i_wdata;
	end

	// next operation goes out in the done cycle so the store can take it at once
	always_comb begin
		o_mem_op = MEM_IDLE;
		o_mem_line_addr = i_addr[ADDR_W-1:OFFSET_W];
		case (state_q)
			C_WRITEBACK: begin
				if (i_mem_done) begin
					o_mem_op = MEM_READ_LINE;
				end else begin
					o_mem_op = MEM_WRITE_LINE;
					o_mem_line_addr = {tag_q[idx], idx};
				end
			end
			C_REFILL: begin
				if (!i_mem_done)
					o_mem_op = MEM_READ_LINE;
			end
			default: begin
				o_mem_op = MEM_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= C_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			case (state_q)
				C_IDLE: begin
					if (req && !hit)
						state_q <= victim_dirty ? C_WRITEBACK : C_REFILL;
					else if (hit_accept && i_write)
						dirty_q[idx] <= 1'b1;
				end
				C_WRITEBACK: begin
					if (i_mem_done) begin
						dirty_q[idx] <= 1'b0;
						state_q <= C_REFILL;
					end
				end
				C_REFILL: begin
					if (i_mem_done) begin
						valid_q[idx] <= 1'b1;
						dirty_q[idx] <= i_write;
						state_q <= C_IDLE;
					end
				end
				default: begin
					state_q <= C_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hit_accept) begin
			if (i_read)
				o_rdata <= data_q[idx][word];
			if (i_write)
				data_q[idx][word] <= i_wdata;
		end else if (refill_done) begin
			data_q[idx] <= fill_line;
			tag_q[idx] <= tag;
			if (i_read)
				o_rdata <= i_mem_rline[word];
		end
	end

endmodule

// File: hw/backing_mem.sv
`timescale 1ns/1ps

module backing_mem #(
	parameter int MEM_DEPTH = 256,
	parameter int MEM_LATENCY = 5
) (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  split_cache_pkg::mem_op_t                i_i_op,
	input  logic [split_cache_pkg::LINE_ADDR_W-1:0] i_i_line_addr,
	output logic                                    o_i_done,
	input  split_cache_pkg::mem_op_t                i_d_op,
	input  logic [split_cache_pkg::LINE_ADDR_W-1:0] i_d_line_addr,
	input  split_cache_pkg::line_t                  i_d_wline,
	output logic                                    o_d_done,
	output split_cache_pkg::line_t                  o_rline
);
	import split_cache_pkg::*;

	localparam int MEM_AW = $clog2(MEM_DEPTH);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [WORD_W-1:0] store_q [MEM_DEPTH];

	logic [CNT_W-1:0] cnt_q;
	mem_op_t cur_op_q;
	logic [LINE_ADDR_W-1:0] cur_line_q;
	logic cur_data_q;

	logic mem_busy;
	logic finish;
	logic [MEM_AW-1:0] base_addr;
	line_t store_line;

	assign mem_busy = (cnt_q != '0);
	assign finish = (cnt_q == CNT_W'(1));

	// only the low address bits reach the store, higher lines alias onto it
	assign base_addr = {cur_line_q[MEM_AW-OFFSET_W-1:0], {OFFSET_W{1'b0}}};

	always_comb begin
		for (int k = 0; k < LINE_WORDS; k++)
			store_line[k] = store_q[base_addr + MEM_AW'(k)];
	end

	// one line operation in flight, done pulses MEM_LATENCY cycles after the grant
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cnt_q <= '0;
			cur_op_q <= MEM_IDLE;
			cur_line_q <= '0;
			cur_data_q <= 1'b0;
			o_i_done <= 1'b0;
			o_d_done <= 1'b0;
		end else begin
			o_i_done <= 1'b0;
			o_d_done <= 1'b0;
			if (!mem_busy) begin
				// data side wins when both wait
				if (i_d_op != MEM_IDLE) begin
					cnt_q <= CNT_W'(MEM_LATENCY);
					cur_op_q <= i_d_op;
					cur_line_q <= i_d_line_addr;
					cur_data_q <= 1'b1;
				end else if (i_i_op != MEM_IDLE) begin
					cnt_q <= CNT_W'(MEM_LATENCY);
					cur_op_q <= i_i_op;
					cur_line_q <= i_i_line_addr;
					cur_data_q <= 1'b0;
				end
			end else begin
				cnt_q <= cnt_q - 1'b1;
				if (finish) begin
					o_d_done <= cur_data_q;
					o_i_done <= !cur_data_q;
				end
			end
		end
	end

	// only the data cache ever writes, and it holds its victim line until done
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int a = 0; a < MEM_DEPTH; a++)
				store_q[a] <= '0;
		end else if (finish && cur_op_q == MEM_WRITE_LINE) begin
			for (int k = 0; k < LINE_WORDS; k++)
				store_q[base_addr + MEM_AW'(k)] <= i_d_wline[k];
		end
	end

	// shared read bus, sampled only by the cache that sees its done
	always_ff @(posedge clk) begin
		if (finish && cur_op_q == MEM_READ_LINE)
			o_rline <= store_line;
	end

endmodule

// File: hw/split_cache_memory.sv
`timescale 1ns/1ps

module split_cache_memory #(
	parameter int N_LINES = 8,
	parameter int MEM_DEPTH = 256,
	parameter int MEM_LATENCY = 5
) (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               i_iread,
	input  logic [split_cache_pkg::ADDR_W-1:0] i_iaddr,
	output logic [split_cache_pkg::WORD_W-1:0] o_idata,
	output logic                               o_ibusy,
	input  logic                               i_dread,
	input  logic                               i_dwrite,
	input  logic [split_cache_pkg::ADDR_W-1:0] i_daddr,
	input  logic [split_cache_pkg::WORD_W-1:0] i_dwdata,
	output logic [split_cache_pkg::WORD_W-1:0] o_drdata,
	output logic                               o_dbusy
);
	import split_cache_pkg::*;

	mem_op_t imem_op;
	logic [LINE_ADDR_W-1:0] imem_line_addr;
	logic imem_done;

	mem_op_t dmem_op;
	logic [LINE_ADDR_W-1:0] dmem_line_addr;
	line_t dmem_wline;
	logic dmem_done;

	// read line is shared, each cache samples it on its own done
	line_t mem_rline;

	icache #(
		.N_LINES(N_LINES)
	) i_icache (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_read         (i_iread),
		.i_addr         (i_iaddr),
		.o_data         (o_idata),
		.o_busy         (o_ibusy),
		.o_mem_op       (imem_op),
		.o_mem_line_addr(imem_line_addr),
		.i_mem_done     (imem_done),
		.i_mem_rline    (mem_rline)
	);

	dcache #(
		.N_LINES(N_LINES)
	) i_dcache (
		.clk            (clk),
		.reset_n        (reset_n),
		.i_read         (i_dread),
		.i_write        (i_dwrite),
		.i_addr         (i_daddr),
		.i_wdata        (i_dwdata),
		.o_rdata        (o_drdata),
		.o_busy         (o_dbusy),
		.o_mem_op       (dmem_op),
		.o_mem_line_addr(dmem_line_addr),
		.o_mem_wline    (dmem_wline),
		.i_mem_done     (dmem_done),
		.i_mem_rline    (mem_rline)
	);

	backing_mem #(
		.MEM_DEPTH  (MEM_DEPTH),
		.MEM_LATENCY(MEM_LATENCY)
	) i_backing_mem (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_i_op       (imem_op),
		.i_i_line_addr(imem_line_addr),
		.o_i_done     (imem_done),
		.i_d_op       (dmem_op),
		.i_d_line_addr(dmem_line_addr),
		.i_d_wline    (dmem_wline),
		.o_d_done     (dmem_done),
		.o_rline      (mem_rline)
	);

endmodule

// File: tests/split_cache_assert.sv
`timescale 1ns/1ps

module split_cache_assert (
	input logic clk,
	input logic reset_n,
	input logic i_iread,
	input logic i_dread,
	input logic i_dwrite,
	input logic i_ibusy,
	input logic i_dbusy,
	input logic i_idone,
	input logic i_ddone
);

	// both ports come out of reset idle
	a_reset_idle: assert property (@(posedge clk) !reset_n |=> (!i_ibusy && !i_dbusy))
		else $error("busy level high in the cycle after reset");

	// a miss can only follow an accepted request
	a_ibusy_cause: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(i_ibusy) |-> $past(i_iread))
		else $error("instruction busy rose without a read request");

	a_dbusy_cause: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(i_dbusy) |-> $past(i_dread || i_dwrite))
		else $error("data busy rose without a read or write request");

	// the store answers only a waiting cache and never both in one cycle
	a_idone_owner: assert property (@(posedge clk) disable iff (!reset_n)
		i_idone |-> (i_ibusy && !i_ddone))
		else $error("instruction done pulse with no instruction miss waiting or with data done");

	a_ddone_owner: assert property (@(posedge clk) disable iff (!reset_n)
		i_ddone |-> i_dbusy)
		else $error("data done pulse with no data miss waiting");

endmodule

bind split_cache_memory split_cache_assert i_split_cache_assert (
	.clk     (clk),
	.reset_n (reset_n),
	.i_iread (i_iread),
	.i_dread (i_dread),
	.i_dwrite(i_dwrite),
	.i_ibusy (o_ibusy),
	.i_dbusy (o_dbusy),
	.i_idone (imem_done),
	.i_ddone (dmem_done)
);

// File: tests/tb_split_cache.sv
`timescale 1ns/1ps

module tb_split_cache;
	import split_cache_pkg::*;

	localparam int N_LINES = 8;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_LATENCY = 5;
	localparam int IDX_W = $clog2(N_LINES);
	localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;
	localparam int MEM_AW = $clog2(MEM_DEPTH);
	localparam int N_REQUESTS = 2000;
	localparam int TIMEOUT_CYCLES = N_REQUESTS * (2 * MEM_LATENCY + 4) * 2;

	// tags 0, 8 and 256 alias in the store, as do 1 and 9
	localparam logic [TAG_W-1:0] TAG_POOL [8] = '{TAG_W'(0), TAG_W'(1), TAG_W'(8),
		TAG_W'(9), TAG_W'(3), TAG_W'(256), TAG_W'(677), TAG_W'(2047)};

	logic clk;
	logic reset_n;
	logic i_iread;
	logic [ADDR_W-1:0] i_iaddr;
	logic [WORD_W-1:0] o_idata;
	logic o_ibusy;
	logic i_dread;
	logic i_dwrite;
	logic [ADDR_W-1:0] i_daddr;
	logic [WORD_W-1:0] i_dwdata;
	logic [WORD_W-1:0] o_drdata;
	logic o_dbusy;

	int errors;
	int cycles;
	logic [31:0] rng_state;

	// reference model of the store and of both caches
	logic [WORD_W-1:0] m_store [MEM_DEPTH];
	logic ic_valid [N_LINES];
	logic [LINE_ADDR_W-1:0] ic_line [N_LINES];
	line_t ic_data [N_LINES];
	logic dc_valid [N_LINES];
	logic dc_dirty [N_LINES];
	logic [LINE_ADDR_W-1:0] dc_line [N_LINES];
	line_t dc_data [N_LINES];

	split_cache_memory #(
		.N_LINES    (N_LINES),
		.MEM_DEPTH  (MEM_DEPTH),
		.MEM_LATENCY(MEM_LATENCY)
	) i_split_cache_memory (
		.clk     (clk),
		.reset_n (reset_n),
		.i_iread (i_iread),
		.i_iaddr (i_iaddr),
		.o_idata (o_idata),
		.o_ibusy (o_ibusy),
		.i_dread (i_dread),
		.i_dwrite(i_dwrite),
		.i_daddr (i_daddr),
		.i_dwdata(i_dwdata),
		.o_drdata(o_drdata),
		.o_dbusy (o_dbusy)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// mostly a few conflicting tags, now and then any address
	function automatic logic [ADDR_W-1:0] rand_addr();
		logic [31:0] r;
		r = next_rand();
		if (r[3:0] == 4'h0)
			return r[31:16];
		return {TAG_POOL[r[6:4]], r[7 +: IDX_W], r[11:10]};
	endfunction

	function automatic logic [MEM_AW-1:0] store_addr(input logic [LINE_ADDR_W-1:0] line,
		input int k);
		return {line[MEM_AW-OFFSET_W-1:0], OFFSET_W'(k)};
	endfunction

	function automatic logic store_line_dirty(input logic [ADDR_W-1:0] addr);
		for (int i = 0; i < N_LINES; i++) begin
			if (dc_valid[IDX_W'(i)] && dc_dirty[IDX_W'(i)] &&
				store_addr(dc_line[IDX_W'(i)], 0) == store_addr(addr[ADDR_W-1:OFFSET_W], 0))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// returns the expected miss length, 0 for a hit
	function automatic int model_dcache(input logic write, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
		logic [IDX_W-1:0] idx;
		logic [LINE_ADDR_W-1:0] line;
		int lat;
		idx = addr[OFFSET_W +: IDX_W];
		line = addr[ADDR_W-1:OFFSET_W];
		lat = 0;
		if (!(dc_valid[idx] && dc_line[idx] == line)) begin
			lat = MEM_LATENCY + 2;
			if (dc_valid[idx] && dc_dirty[idx]) begin
				lat = 2 * MEM_LATENCY + 3;
				for (int k = 0; k < LINE_WORDS; k++)
					m_store[store_addr(dc_line[idx], k)] = dc_data[idx][OFFSET_W'(k)];
			end
			for (int k = 0; k < LINE_WORDS; k++)
				dc_data[idx][OFFSET_W'(k)] = m_store[store_addr(line, k)];
			dc_valid[idx] = 1'b1;
			dc_dirty[idx] = 1'b0;
			dc_line[idx] = line;
		end
		rdata = dc_data[idx][addr[OFFSET_W-1:0]];
		if (write) begin
			dc_data[idx][addr[OFFSET_W-1:0]] = wdata;
			dc_dirty[idx] = 1'b1;
		end
		return lat;
	endfunction

	function automatic int model_icache(input logic [ADDR_W-1:0] addr,
		output logic [WORD_W-1:0] rdata);
		logic [IDX_W-1:0] idx;
		logic [LINE_ADDR_W-1:0] line;
		int lat;
		idx = addr[OFFSET_W +: IDX_W];
		line = addr[ADDR_W-1:OFFSET_W];
		lat = 0;
		if (!(ic_valid[idx] && ic_line[idx] == line)) begin
			lat = MEM_LATENCY + 2;
			for (int k = 0; k < LINE_WORDS; k++)
				ic_data[idx][OFFSET_W'(k)] = m_store[store_addr(line, k)];
			ic_valid[idx] = 1'b1;
			ic_line[idx] = line;
		end
		rdata = ic_data[idx][addr[OFFSET_W-1:0]];
		return lat;
	endfunction

	// request is held until busy is seen low at a falling edge
	task automatic data_access(input logic write, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, input logic timed);
		logic [WORD_W-1:0] exp;
		int lat;
		int n;
		lat = model_dcache(write, addr, wdata, exp);
		@(negedge clk);
		i_dread = !write;
		i_dwrite = write;
		i_daddr = addr;
		i_dwdata = wdata;
		@(negedge clk);
		check_busy("o_dbusy", lat != 0, o_dbusy);
		n = 0;
		while (o_dbusy) begin
			n++;
			@(negedge clk);
		end
		i_dread = 1'b0;
		i_dwrite = 1'b0;
		if (!write)
			check_word("o_drdata", exp, o_drdata);
		if (timed)
			check_cycles("data access cycles", lat, n);
	endtask

	task automatic inst_read(input logic [ADDR_W-1:0] addr, input logic timed);
		logic [WORD_W-1:0] exp;
		int lat;
		int n;
		lat = model_icache(addr, exp);
		@(negedge clk);
		i_iread = 1'b1;
		i_iaddr = addr;
		@(negedge clk);
		check_busy("o_ibusy", lat != 0, o_ibusy);
		n = 0;
		while (o_ibusy) begin
			n++;
			@(negedge clk);
		end
		i_iread = 1'b0;
		check_word("o_idata", exp, o_idata);
		if (timed)
			check_cycles("instruction read cycles", lat, n);
	endtask

	initial begin
		logic [ADDR_W-1:0] ia;
		logic [ADDR_W-1:0] da;
		logic [31:0] r;
		clk = 1'b0;
		reset_n = 1'b0;
		i_iread = 1'b0;
		i_iaddr = '0;
		i_dread = 1'b0;
		i_dwrite = 1'b0;
		i_daddr = '0;
		i_dwdata = '0;
		errors = 0;
		cycles = 0;
		rng_state = 32'd24837;
		m_store = '{default: '0};
		ic_valid = '{default: 1'b0};
		dc_valid = '{default: 1'b0};
		dc_dirty = '{default: 1'b0};
		repeat (4) @(negedge clk);
		reset_n = 1'b1;
		check_busy("o_ibusy", 1'b0, o_ibusy);
		check_busy("o_dbusy", 1'b0, o_dbusy);

		// first reads after reset see the cleared store
		data_access(1'b0, 16'h0040, '0, 1'b1);
		inst_read(16'h0080, 1'b1);

		repeat (800) begin
			r = next_rand();
			data_access(r[0], rand_addr(), r[31:16], 1'b1);
		end

		// dirty line evicted by an aliasing tag, then by a plain conflict
		for (int k = 0; k < LINE_WORDS; k++)
			data_access(1'b1, 16'h000c + ADDR_W'(k), WORD_W'(next_rand()), 1'b1);
		for (int k = 0; k < LINE_WORDS; k++)
			data_access(1'b0, 16'h010c + ADDR_W'(k), '0, 1'b1);
		data_access(1'b1, 16'h002c, WORD_W'(next_rand()), 1'b1);
		for (int k = 0; k < LINE_WORDS; k++)
			data_access(1'b0, 16'h000c + ADDR_W'(k), '0, 1'b1);

		// resident instruction line keeps stale data until it is refilled
		inst_read(16'h0050, 1'b1);
		data_access(1'b1, 16'h0050, 16'hbeef, 1'b1);
		inst_read(16'h0050, 1'b1);
		data_access(1'b0, 16'h0070, '0, 1'b1);
		inst_read(16'h0070, 1'b1);
		inst_read(16'h0050, 1'b1);

		// both ports issue in the same cycle, instruction side avoids dirty store lines
		repeat (300) begin
			ia = rand_addr();
			while (store_line_dirty(ia))
				ia = rand_addr();
			da = rand_addr();
			fork
				inst_read(ia, 1'b0);
				data_access(1'b0, da, '0, 1'b0);
			join
		end

		repeat (400) begin
			r = next_rand();
			if (r[1:0] == 2'd0)
				inst_read(rand_addr(), 1'b1);
			else
				data_access(r[1], rand_addr(), r[31:16], 1'b1);
		end

		@(negedge clk);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: compile.f
hw/split_cache_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/backing_mem.sv
hw/split_cache_memory.sv
tests/split_cache_assert.sv
tests/tb_split_cache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_split_cache
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Finished with errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "simulator exited with an error status" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "$(FAIL_MSG)" -e "simulator exited with an error status" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
